// ==== build.f ====
verilog/fetch_pkg.sv
verilog/instr_mem.sv
verilog/branch_predictor.sv
verilog/fetch_group_decode.sv
verilog/pc_sequencer.sv
verilog/fetch_top.sv
+incdir+testbench
testbench/fetch_tb.sv

// ==== testbench/fetch_model.svh ====
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

//////////////////////////////
// model state
//////////////////////////////

// copy of the loaded program
inst_t    model_mem [IMEM_DEPTH];
// two-bit counters, one per low pc index
counter_t model_cnt [BP_ENTRIES];
// pc of the group shown this cycle
pc_t      model_pc;

// expected decode outputs for model_pc
logic [PC_GROUP_WIDTH-1:0] exp_pc_dec;
logic [GROUP_WIDTH-1:0]    exp_inst_dec;
logic [PC_GROUP_WIDTH-1:0] exp_recv_dec;
slot_mask_t                exp_pred;
slot_mask_t                exp_valid;
logic                      exp_redirect;
pc_t                       exp_target;

function automatic void reset_counters();
    for (int i = 0; i < BP_ENTRIES; i++) begin
        model_cnt[i] = CNT_INIT;
    end
endfunction

// group rules, walked slot by slot
task automatic predict_group(input pc_t base);
    pc_t   spc;
    inst_t word;
    logic  taken;
    logic  cut;
    int    off;
    pc_t   target;
    exp_pc_dec   = '0;
    exp_inst_dec = '0;
    exp_recv_dec = '0;
    exp_pred     = '0;
    exp_valid    = '0;
    exp_redirect = 1'b0;
    exp_target   = '0;
    cut          = 1'b0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
        spc   = pc_t'(base + s);
        word  = model_mem[spc[IMEM_ADDR_BITS-1:0]];
        taken = (model_cnt[spc[BP_INDEX_BITS-1:0]] >= 2'd2);
        exp_pc_dec[s*PC_WIDTH +: PC_WIDTH]       = spc;
        exp_inst_dec[s*INST_WIDTH +: INST_WIDTH] = word;
        // valid through the first redirecting slot
        if (!cut) begin
            exp_valid[s] = 1'b1;
        end
        if (word[15:12] == OPC_BRANCH) begin
            off = int'(word[7:0]);
            if (off > 127) begin
                off = off - 256;
            end
            target = pc_t'(int'(spc) + 1 + off);
            exp_pred[s] = taken;
            // alternate path of the prediction
            exp_recv_dec[s*PC_WIDTH +: PC_WIDTH] = taken ? pc_t'(spc + 1) : target;
            if (!cut && taken) begin
                cut          = 1'b1;
                exp_redirect = 1'b1;
                exp_target   = target;
            end
        end else if (word[15:12] == OPC_JUMP) begin
            target = {spc[15:12], word[11:0]};
            if (!cut) begin
                cut          = 1'b1;
                exp_redirect = 1'b1;
                exp_target   = target;
            end
        end
    end
endtask

// saturating step of one counter
task automatic apply_commit(input pc_t cpc, input logic taken);
    int idx;
    idx = int'(cpc[BP_INDEX_BITS-1:0]);
    if (taken && model_cnt[idx] < 2'd3) begin
        model_cnt[idx] = model_cnt[idx] + 2'd1;
    end else if (!taken && model_cnt[idx] > 2'd0) begin
        model_cnt[idx] = model_cnt[idx] - 2'd1;
    end
endtask

// priority: external, mispredict, stall, redirect, plus four
function automatic pc_t model_next_pc(input logic ext_en, input pc_t ext_pc,
                                      input logic mis, input pc_t rec, input logic stall);
    if (ext_en) begin
        return ext_pc;
    end
    if (mis) begin
        return rec;
    end
    if (stall) begin
        return model_pc;
    end
    if (exp_redirect) begin
        return exp_target;
    end
    return pc_t'(model_pc + 16'd4);
endfunction

`endif

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int RUN_CYCLES      = 3000;
    localparam int LOAD_CYCLES     = 300;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES + LOAD_CYCLES;
    localparam logic [31:0] SEED   = 32'he140_0b8f;

    logic clk;
    logic rst_n;
    logic stall_fetch;
    logic has_mispredict;
    pc_t  pc_recovery;
    pc_t  exter_pc;
    logic exter_pc_en;
    logic commit_en;
    pc_t  commit_pc;
    logic commit_taken;
    logic imem_wr_en;
    pc_t  imem_wr_addr;
    inst_t imem_wr_data;

    logic                      fetch_valid;
    slot_mask_t                slot_valid;
    logic [PC_GROUP_WIDTH-1:0] pc_to_dec;
    logic [GROUP_WIDTH-1:0]    inst_to_dec;
    logic [PC_GROUP_WIDTH-1:0] recv_pc_to_dec;
    slot_mask_t                pred_result_to_dec;

    logic [31:0] lcg_state;
    // set once the first valid group is seen
    logic        started;

`include "fetch_model.svh"

    fetch_top i_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .stall_fetch        (stall_fetch),
        .has_mispredict     (has_mispredict),
        .pc_recovery        (pc_recovery),
        .exter_pc           (exter_pc),
        .exter_pc_en        (exter_pc_en),
        .commit_en          (commit_en),
        .commit_pc          (commit_pc),
        .commit_taken       (commit_taken),
        .imem_wr_en         (imem_wr_en),
        .imem_wr_addr       (imem_wr_addr),
        .imem_wr_data       (imem_wr_data),
        .fetch_valid        (fetch_valid),
        .slot_valid         (slot_valid),
        .pc_to_dec          (pc_to_dec),
        .inst_to_dec        (inst_to_dec),
        .recv_pc_to_dec     (recv_pc_to_dec),
        .pred_result_to_dec (pred_result_to_dec)
    );

    //////////////////////////////
    // random source
    //////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic percent_draw(input int pct);
        return ((next_rand() >> 8) % 100) < pct;
    endfunction

    // about 20% branches, 10% jumps
    function automatic inst_t random_word();
        int          kind;
        logic [31:0] bits;
        opc_t        opc;
        kind = int'((next_rand() >> 8) % 100);
        bits = next_rand();
        opc  = bits[31:28];
        if (kind < 20) begin
            return {OPC_BRANCH, bits[27:16]};
        end
        if (kind < 30) begin
            return {OPC_JUMP, bits[27:16]};
        end
        // keep other words off the two control opcodes
        if (opc == OPC_BRANCH || opc == OPC_JUMP) begin
            opc = opc ^ 4'h8;
        end
        return {opc, bits[27:16]};
    endfunction

    task automatic drive_random_inputs();
        stall_fetch    <= percent_draw(15);
        has_mispredict <= percent_draw(5);
        pc_recovery    <= pc_t'(next_rand() >> 16);
        exter_pc_en    <= percent_draw(2);
        exter_pc       <= pc_t'(next_rand() >> 16);
        commit_en      <= percent_draw(30);
        commit_pc      <= pc_t'(next_rand() >> 16);
        commit_taken   <= percent_draw(50);
    endtask

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // compare current group, then step pc and counters
    task automatic check_cycle();
        logic exp_fv;
        exp_fv = !(exter_pc_en || has_mispredict || stall_fetch);
        predict_group(model_pc);
        check_value("fetch_valid", exp_fv, fetch_valid);
        check_value("pc_to_dec", exp_pc_dec, pc_to_dec);
        check_value("inst_to_dec", exp_inst_dec, inst_to_dec);
        check_value("recv_pc_to_dec", exp_recv_dec, recv_pc_to_dec);
        check_value("pred_result_to_dec", exp_pred, pred_result_to_dec);
        check_value("slot_valid", exp_valid, slot_valid);
        model_pc = model_next_pc(exter_pc_en, exter_pc, has_mispredict, pc_recovery,
                                 stall_fetch);
        // lookups this cycle used the old counters
        if (commit_en) begin
            apply_commit(commit_pc, commit_taken);
        end
    endtask

    // outputs sampled mid cycle with inputs settled
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("fetch_valid in reset", 64'd0, {63'd0, fetch_valid});
        end else begin
            if (!started && fetch_valid === 1'b1) begin
                started  = 1'b1;
                model_pc = '0;
            end
            if (started) begin
                check_cycle();
            end
        end
    end

    //////////////////////////////
    // clock, reset, stimulus
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        inst_t word;
        rst_n          = 1'b0;
        stall_fetch    = 1'b0;
        has_mispredict = 1'b0;
        pc_recovery    = '0;
        exter_pc       = '0;
        exter_pc_en    = 1'b0;
        commit_en      = 1'b0;
        commit_pc      = '0;
        commit_taken   = 1'b0;
        imem_wr_en     = 1'b0;
        imem_wr_addr   = '0;
        imem_wr_data   = '0;
        lcg_state      = SEED;
        started        = 1'b0;
        reset_counters();
        // program load while the core sits in reset
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            @(posedge clk);
            word         = random_word();
            model_mem[a] = word;
            imem_wr_en   <= 1'b1;
            imem_wr_addr <= pc_t'(a);
            imem_wr_data <= word;
        end
        @(posedge clk);
        imem_wr_en <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_n <= 1'b1;
        // first valid group starts the model
        while (!started) begin
            @(posedge clk);
        end
        for (int c = 0; c < RUN_CYCLES; c++) begin
            drive_random_inputs();
            @(posedge clk);
        end
        // last group checked on the negedge before this
        @(posedge clk);
        $display("Test OK");
        $finish;
    end

    // hang guard sized for run length plus load time
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run hung, no result after %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // from decode and rob
    input  logic                      stall_fetch,
    input  logic                      has_mispredict,
    input  pc_t                       pc_recovery,
    // external pc load
    input  pc_t                       exter_pc,
    input  logic                      exter_pc_en,
    // predictor training from commit
    input  logic                      commit_en,
    input  pc_t                       commit_pc,
    input  logic                      commit_taken,
    // program loader
    input  logic                      imem_wr_en,
    input  pc_t                       imem_wr_addr,
    input  inst_t                     imem_wr_data,
    // to decode
    output logic                      fetch_valid,
    output slot_mask_t                slot_valid,
    output logic [PC_GROUP_WIDTH-1:0] pc_to_dec,
    output logic [GROUP_WIDTH-1:0]    inst_to_dec,
    output logic [PC_GROUP_WIDTH-1:0] recv_pc_to_dec,
    output slot_mask_t                pred_result_to_dec
);

    //////////////////////////////
    // internal wires
    //////////////////////////////

    pc_t                    pc;
    pc_t                    next_pc;
    logic [GROUP_WIDTH-1:0] inst_group;
    slot_mask_t             pred_taken;
    logic                   redirect;
    pc_t                    redirect_pc;

    // memory reads at next_pc so the group lines up with pc
    instr_mem i_instr_mem (
        .clk        (clk),
        .rd_addr    (next_pc),
        .inst_group (inst_group),
        .wr_en      (imem_wr_en),
        .wr_addr    (imem_wr_addr),
        .wr_data    (imem_wr_data)
    );

    branch_predictor i_branch_predictor (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .pred_taken   (pred_taken),
        .commit_en    (commit_en),
        .commit_pc    (commit_pc),
        .commit_taken (commit_taken)
    );

    fetch_group_decode i_fetch_group_decode (
        .pc                 (pc),
        .inst_group         (inst_group),
        .pred_taken         (pred_taken),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .pc_to_dec          (pc_to_dec),
        .inst_to_dec        (inst_to_dec),
        .recv_pc_to_dec     (recv_pc_to_dec),
        .pred_result_to_dec (pred_result_to_dec),
        .slot_valid         (slot_valid)
    );

    pc_sequencer i_pc_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_fetch    (stall_fetch),
        .has_mispredict (has_mispredict),
        .exter_pc_en    (exter_pc_en),
        .pc_recovery    (pc_recovery),
        .exter_pc       (exter_pc),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .pc             (pc),
        .next_pc        (next_pc),
        .fetch_valid    (fetch_valid)
    );

endmodule

// ==== verilog/pc_sequencer.sv ====
`timescale 1ns/1ps

module pc_sequencer
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    // control from decode, rob and external
    input  logic stall_fetch,
    input  logic has_mispredict,
    input  logic exter_pc_en,
    input  pc_t  pc_recovery,
    input  pc_t  exter_pc,
    // predicted redirect from group decode
    input  logic redirect,
    input  pc_t  redirect_pc,
    // registered pc and its next value
    output pc_t  pc,
    output pc_t  next_pc,
    output logic fetch_valid
);

    //////////////////////////////
    // start-up fsm
    //////////////////////////////

    seq_state_t state;
    seq_state_t state_nxt;

    // sequential successor of the group
    pc_t pc_plus_group;

    // reset, then one cycle priming memory at address 0, then run
    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_RESET: state_nxt = SEQ_PRIME;
            SEQ_PRIME: state_nxt = SEQ_RUN;
            SEQ_RUN:   state_nxt = SEQ_RUN;
            default:   state_nxt = SEQ_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////
    // next pc selection
    //////////////////////////////

    assign pc_plus_group = pc + PC_WIDTH'(FETCH_WIDTH);

    // highest priority first
    always_comb begin
        if (state != SEQ_RUN) begin
            // memory primed with address 0
            next_pc = '0;
        end else if (exter_pc_en) begin
            next_pc = exter_pc;
        end else if (has_mispredict) begin
            next_pc = pc_recovery;
        end else if (stall_fetch) begin
            // hold, same group read again
            next_pc = pc;
        end else if (redirect) begin
            next_pc = redirect_pc;
        end else begin
            next_pc = pc_plus_group;
        end
    end

    // pc and memory load next_pc on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    //////////////////////////////
    // group valid to decode
    //////////////////////////////

    // any of the three controls kills the current group
    assign fetch_valid = (state == SEQ_RUN) & ~exter_pc_en & ~has_mispredict & ~stall_fetch;

endmodule

// ==== verilog/fetch_group_decode.sv ====
`timescale 1ns/1ps

module fetch_group_decode
    import fetch_pkg::*;
(
    input  pc_t                       pc,
    input  logic [GROUP_WIDTH-1:0]    inst_group,
    input  slot_mask_t                pred_taken,
    // to pc sequencer
    output logic                      redirect,
    output pc_t                       redirect_pc,
    // packed for decode, slot 0 in the low bits
    output logic [PC_GROUP_WIDTH-1:0] pc_to_dec,
    output logic [GROUP_WIDTH-1:0]    inst_to_dec,
    output logic [PC_GROUP_WIDTH-1:0] recv_pc_to_dec,
    output slot_mask_t                pred_result_to_dec,
    output slot_mask_t                slot_valid
);

    //////////////////////////////
    // per slot predecode
    //////////////////////////////

    pc_t   slot_pc    [FETCH_WIDTH];
    pc_t   seq_pc     [FETCH_WIDTH];
    inst_t slot_inst  [FETCH_WIDTH];
    opc_t  slot_opc   [FETCH_WIDTH];
    pc_t   br_offset  [FETCH_WIDTH];
    pc_t   br_target  [FETCH_WIDTH];
    pc_t   jmp_target [FETCH_WIDTH];
    pc_t   recv_pc    [FETCH_WIDTH];

    slot_mask_t is_br;
    slot_mask_t is_jmp;
    // jump, or branch predicted taken
    slot_mask_t redir_slot;

    genvar s;
    generate
        for (s = 0; s < FETCH_WIDTH; s++) begin : g_slot
            assign slot_pc[s]   = pc + PC_WIDTH'(s);
            assign seq_pc[s]    = slot_pc[s] + 1'b1;
            assign slot_inst[s] = inst_group[s*INST_WIDTH +: INST_WIDTH];
            assign slot_opc[s]  = slot_inst[s][INST_WIDTH-1 -: OPC_BITS];

            // opcode classes
            assign is_br[s]  = (slot_opc[s] == OPC_BRANCH);
            assign is_jmp[s] = (slot_opc[s] == OPC_JUMP);

            // sign extended word offset, relative to slot pc plus one
            assign br_offset[s] = {{(PC_WIDTH-BR_OFF_BITS){slot_inst[s][BR_OFF_BITS-1]}},
                                   slot_inst[s][BR_OFF_BITS-1:0]};
            assign br_target[s] = seq_pc[s] + br_offset[s];

            // upper pc bits kept, low 12 from the instruction
            assign jmp_target[s] = {slot_pc[s][PC_WIDTH-1:JMP_OFF_BITS],
                                    slot_inst[s][JMP_OFF_BITS-1:0]};

            assign redir_slot[s] = is_jmp[s] | (is_br[s] & pred_taken[s]);

            // alternate path for a branch, zero for anything else
            assign recv_pc[s] = !is_br[s]      ? '0 :
                                pred_taken[s]  ? seq_pc[s] :
                                                 br_target[s];
        end
    endgenerate

    //////////////////////////////
    // group cut
    //////////////////////////////

    // first redirecting slot ends the group
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        slot_valid  = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!redirect) begin
                // valid up to and including the cut slot
                slot_valid[i] = 1'b1;
                if (redir_slot[i]) begin
                    redirect    = 1'b1;
                    redirect_pc = is_jmp[i] ? jmp_target[i] : br_target[i];
                end
            end
        end
    end

    //////////////////////////////
    // pack for decode
    //////////////////////////////

    generate
        for (s = 0; s < FETCH_WIDTH; s++) begin : g_pack
            assign pc_to_dec[s*PC_WIDTH +: PC_WIDTH]       = slot_pc[s];
            assign inst_to_dec[s*INST_WIDTH +: INST_WIDTH] = slot_inst[s];
            assign recv_pc_to_dec[s*PC_WIDTH +: PC_WIDTH]  = recv_pc[s];
        end
    endgenerate

    // prediction only meaningful on branch slots
    assign pred_result_to_dec = pred_taken & is_br;

endmodule

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // lookup, base pc of the group
    input  pc_t        pc,
    output slot_mask_t pred_taken,
    // training from commit
    input  logic       commit_en,
    input  pc_t        commit_pc,
    input  logic       commit_taken
);

    //////////////////////////////
    // counter table
    //////////////////////////////

    counter_t cnt_table [BP_ENTRIES];

    logic [BP_INDEX_BITS-1:0] rd_idx [FETCH_WIDTH];
    logic [BP_INDEX_BITS-1:0] wr_idx;
    pc_t                      slot_pc [FETCH_WIDTH];

    //////////////////////////////
    // four lookups
    //////////////////////////////

    genvar s;
    generate
        for (s = 0; s < FETCH_WIDTH; s++) begin : g_lookup
            // pc+0 .. pc+3
            assign slot_pc[s]    = pc + PC_WIDTH'(s);
            assign rd_idx[s]     = slot_pc[s][BP_INDEX_BITS-1:0];
            // taken when counter is 2 or 3
            assign pred_taken[s] = cnt_table[rd_idx[s]][CNT_BITS-1];
        end
    endgenerate

    //////////////////////////////
    // commit update
    //////////////////////////////

    assign wr_idx = commit_pc[BP_INDEX_BITS-1:0];

    // lookups this cycle still see the old value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < BP_ENTRIES; i++) begin
                cnt_table[i] <= CNT_INIT;
            end
        end else if (commit_en) begin
            if (commit_taken) begin
                // saturate at 3
                if (cnt_table[wr_idx] != '1) begin
                    cnt_table[wr_idx] <= cnt_table[wr_idx] + 2'd1;
                end
            end else begin
                // saturate at 0
                if (cnt_table[wr_idx] != '0) begin
                    cnt_table[wr_idx] <= cnt_table[wr_idx] - 2'd1;
                end
            end
        end
    end

endmodule

// ==== verilog/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem
    import fetch_pkg::*;
(
    input  logic                   clk,
    // read side, four consecutive words per cycle
    input  pc_t                    rd_addr,
    output logic [GROUP_WIDTH-1:0] inst_group,
    // loader write port
    input  logic                   wr_en,
    input  pc_t                    wr_addr,
    input  inst_t                  wr_data
);

    //////////////////////////////
    // storage
    //////////////////////////////

    inst_t mem [IMEM_DEPTH];

    // per slot word index, wraps at the top of memory
    logic [IMEM_ADDR_BITS-1:0] rd_idx [FETCH_WIDTH];

    genvar s;
    generate
        for (s = 0; s < FETCH_WIDTH; s++) begin : g_rd_idx
            assign rd_idx[s] = rd_addr[IMEM_ADDR_BITS-1:0] + IMEM_ADDR_BITS'(s);
        end
    endgenerate

    // registered read, slot 0 in the low bits
    always_ff @(posedge clk) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            inst_group[i*INST_WIDTH +: INST_WIDTH] <= mem[rd_idx[i]];
        end
    end

    // single word write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[IMEM_ADDR_BITS-1:0]] <= wr_data;
        end
    end

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    //////////////////////////////
    // widths and sizes
    //////////////////////////////

    // word addresses and instruction words
    localparam int PC_WIDTH       = 16;
    localparam int INST_WIDTH     = 16;
    // slots per fetch group
    localparam int FETCH_WIDTH    = 4;
    localparam int GROUP_WIDTH    = FETCH_WIDTH * INST_WIDTH;
    localparam int PC_GROUP_WIDTH = FETCH_WIDTH * PC_WIDTH;

    // 256 word instruction memory, wraps modulo depth
    localparam int IMEM_ADDR_BITS = 8;
    localparam int IMEM_DEPTH     = 1 << IMEM_ADDR_BITS;

    // 64 entry counter table, indexed by low pc bits
    localparam int BP_INDEX_BITS  = 6;
    localparam int BP_ENTRIES     = 1 << BP_INDEX_BITS;
    localparam int CNT_BITS       = 2;

    // instruction fields
    localparam int OPC_BITS       = 4;
    localparam int BR_OFF_BITS    = 8;
    localparam int JMP_OFF_BITS   = 12;

    //////////////////////////////
    // types
    //////////////////////////////

    typedef logic [PC_WIDTH-1:0]    pc_t;
    typedef logic [INST_WIDTH-1:0]  inst_t;
    // slot 0 in bit 0
    typedef logic [FETCH_WIDTH-1:0] slot_mask_t;
    typedef logic [CNT_BITS-1:0]    counter_t;
    typedef logic [OPC_BITS-1:0]    opc_t;

    // start-up sequence of the pc sequencer
    typedef enum logic [1:0] {
        SEQ_RESET,
        SEQ_PRIME,
        SEQ_RUN
    } seq_state_t;

    //////////////////////////////
    // encodings
    //////////////////////////////

    // conditional branch, low 8 bits signed word offset
    localparam opc_t OPC_BRANCH = 4'hc;
    // immediate jump, low 12 bits replace low 12 bits of pc
    localparam opc_t OPC_JUMP   = 4'hd;

    // weakly not taken
    localparam counter_t CNT_INIT = 2'd1;

endpackage
